/* source/dsp_params.svh */
`ifndef DSP_PARAMS_SVH
`define DSP_PARAMS_SVH

// Program memory address width and register count
`define DSP_PM_AW      8
`define DSP_NUM_REGS   16

// Opcodes
`define OP_NOP         6'h00
`define OP_LDI         6'h01
`define OP_ADD         6'h02
`define OP_SUB         6'h03
`define OP_AND         6'h04
`define OP_OR          6'h05
`define OP_MAC         6'h06
`define OP_CLRACC      6'h07
`define OP_RDACC       6'h08
`define OP_IN          6'h09
`define OP_OUT         6'h0a
`define OP_BNZ         6'h0b
`define OP_HALT        6'h3f

// Instruction fields, imm overlaps the low bits of rb
`define INSTR_OP_HI    31
`define INSTR_OP_LO    26
`define INSTR_RD_HI    25
`define INSTR_RD_LO    22
`define INSTR_RA_HI    21
`define INSTR_RA_LO    18
`define INSTR_RB_HI    17
`define INSTR_RB_LO    14
`define INSTR_IMM_HI   15
`define INSTR_IMM_LO   0

`endif

/* source/dsp_pkg.sv */
`include "dsp_params.svh"

package dsp_pkg;

   // Data path words
   typedef logic [15:0] word_t;
   typedef logic [31:0] instr_t;
   typedef logic [31:0] acc_t;

   // Addresses and indices
   typedef logic [`DSP_PM_AW-1:0] pm_addr_t;
   typedef logic [3:0]            reg_idx_t;
   typedef logic [7:0]            io_addr_t;
   typedef logic [5:0]            opcode_t;

   // Run control of the fetch unit
   typedef enum logic {
      IDLE,
      RUN
   } run_state_e;

   // Control word handed from decode to execute
   typedef struct packed {
      logic     valid;
      opcode_t  opcode;
      reg_idx_t rd;
      logic     writes_rd;
      word_t    opa;
      word_t    opb;
      word_t    imm;
      pm_addr_t target;
   } decoded_op_t;

endpackage

/* source/program_memory.sv */
`include "dsp_params.svh"

module program_memory (
   input  logic              clk_i,
   input  logic              prog_wr_i,
   input  dsp_pkg::pm_addr_t prog_addr_i,
   input  dsp_pkg::instr_t   prog_data_i,
   input  dsp_pkg::pm_addr_t rd_addr_i,
   output dsp_pkg::instr_t   rd_data_o
);
   import dsp_pkg::*;

   localparam int PM_DEPTH = 1 << `DSP_PM_AW;

   instr_t mem [PM_DEPTH];

   // Loader port
   always_ff @(posedge clk_i) begin
      if (prog_wr_i) begin
         mem[prog_addr_i] <= prog_data_i;
      end
   end

   // Fetch port, one cycle read latency
   always_ff @(posedge clk_i) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

/* source/fetch_unit.sv */
`include "dsp_params.svh"

module fetch_unit (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              start_i,
   input  logic              jump_taken_i,
   input  dsp_pkg::pm_addr_t jump_target_i,
   input  logic              halt_i,
   output dsp_pkg::pm_addr_t pc_o,
   input  dsp_pkg::instr_t   instr_i,
   output dsp_pkg::instr_t   instr_o,
   output logic              fetch_valid_o,
   output logic              running_o
);
   import dsp_pkg::*;

   run_state_e state_q;
   pm_addr_t   pc_q;
   logic       fetch_valid_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q       <= IDLE;
         pc_q          <= '0;
         fetch_valid_q <= 1'b0;
      end else begin
         // Word read this cycle is dropped on a redirect or halt
         fetch_valid_q <= (state_q == RUN) && !jump_taken_i && !halt_i;
         case (state_q)
            IDLE: begin
               if (start_i) begin
                  state_q <= RUN;
                  pc_q    <= '0;
               end
            end
            RUN: begin
               if (halt_i) begin
                  state_q <= IDLE;
               end else if (jump_taken_i) begin
                  pc_q <= jump_target_i;
               end else begin
                  pc_q <= pc_q + 1'b1;
               end
            end
         endcase
      end
   end

   assign pc_o          = pc_q;
   assign fetch_valid_o = fetch_valid_q;
   assign running_o     = (state_q == RUN);

   // Nop insertion for squashed words
   assign instr_o = fetch_valid_q ? instr_i : instr_t'({`OP_NOP, 26'd0});

endmodule

/* source/instruction_decoder.sv */
`include "dsp_params.svh"

module instruction_decoder (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  dsp_pkg::instr_t      instr_i,
   input  logic                 fetch_valid_i,
   input  logic                 flush_i,
   output dsp_pkg::reg_idx_t    rd_a_idx_o,
   output dsp_pkg::reg_idx_t    rd_b_idx_o,
   input  dsp_pkg::word_t       rd_a_i,
   input  dsp_pkg::word_t       rd_b_i,
   input  logic                 wb_en_i,
   input  dsp_pkg::reg_idx_t    wb_idx_i,
   input  dsp_pkg::word_t       wb_data_i,
   output dsp_pkg::decoded_op_t dec_op_o
);
   import dsp_pkg::*;

   opcode_t     op;
   reg_idx_t    ra_idx;
   reg_idx_t    rb_idx;
   decoded_op_t dec_next;

   assign op     = instr_i[`INSTR_OP_HI:`INSTR_OP_LO];
   assign ra_idx = instr_i[`INSTR_RA_HI:`INSTR_RA_LO];
   assign rb_idx = instr_i[`INSTR_RB_HI:`INSTR_RB_LO];

   assign rd_a_idx_o = ra_idx;
   assign rd_b_idx_o = rb_idx;

   always_comb begin
      dec_next        = '0;
      dec_next.valid  = fetch_valid_i & ~flush_i;
      dec_next.opcode = op;
      dec_next.rd     = instr_i[`INSTR_RD_HI:`INSTR_RD_LO];
      dec_next.imm    = instr_i[`INSTR_IMM_HI:`INSTR_IMM_LO];
      dec_next.target = instr_i[`DSP_PM_AW-1:0];

      // Bypass the result being written back this cycle
      dec_next.opa = (wb_en_i && (wb_idx_i == ra_idx)) ? wb_data_i : rd_a_i;
      dec_next.opb = (wb_en_i && (wb_idx_i == rb_idx)) ? wb_data_i : rd_b_i;

      case (op)
         `OP_LDI, `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_RDACC, `OP_IN: begin
            dec_next.writes_rd = 1'b1;
         end
         `OP_NOP, `OP_MAC, `OP_CLRACC, `OP_OUT, `OP_BNZ, `OP_HALT: begin
            dec_next.writes_rd = 1'b0;
         end
         default: begin
            // Unknown opcode runs as a nop
            dec_next.opcode    = `OP_NOP;
            dec_next.writes_rd = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dec_op_o <= '0;
      end else begin
         dec_op_o <= dec_next;
      end
   end

endmodule

/* source/register_file.sv */
`include "dsp_params.svh"

module register_file (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  dsp_pkg::reg_idx_t rd_a_idx_i,
   input  dsp_pkg::reg_idx_t rd_b_idx_i,
   output dsp_pkg::word_t    rd_a_o,
   output dsp_pkg::word_t    rd_b_o,
   input  logic              wr_en_i,
   input  dsp_pkg::reg_idx_t wr_idx_i,
   input  dsp_pkg::word_t    wr_data_i
);
   import dsp_pkg::*;

   word_t regs_q [`DSP_NUM_REGS];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `DSP_NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en_i) begin
         regs_q[wr_idx_i] <= wr_data_i;
      end
   end

   // Reads see the old value during a write, decode bypasses it
   assign rd_a_o = regs_q[rd_a_idx_i];
   assign rd_b_o = regs_q[rd_b_idx_i];

endmodule

/* source/execute_unit.sv */
`include "dsp_params.svh"

module execute_unit (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  dsp_pkg::decoded_op_t dec_op_i,
   output logic                 wb_en_o,
   output dsp_pkg::reg_idx_t    wb_idx_o,
   output dsp_pkg::word_t       wb_data_o,
   output logic                 jump_taken_o,
   output dsp_pkg::pm_addr_t    jump_target_o,
   output logic                 halt_o,
   output dsp_pkg::io_addr_t    io_addr_o,
   output dsp_pkg::word_t       io_data_o,
   input  dsp_pkg::word_t       io_data_i,
   output logic                 io_wr_strobe_o,
   output logic                 io_rd_strobe_o
);
   import dsp_pkg::*;

   acc_t               acc_q;
   logic signed [31:0] product;
   word_t              acc_sat;
   word_t              result;
   logic               is_halt;
   logic               bnz_taken;

   assign product = $signed(dec_op_i.opa) * $signed(dec_op_i.opb);

   // MAC accumulator, wraps on overflow
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         acc_q <= '0;
      end else if (dec_op_i.valid) begin
         if (dec_op_i.opcode == `OP_MAC) begin
            acc_q <= acc_q + acc_t'(product);
         end else if (dec_op_i.opcode == `OP_CLRACC) begin
            acc_q <= '0;
         end
      end
   end

   // Clip to signed 16 bits on readout
   always_comb begin
      if ($signed(acc_q) > 32'sd32767) begin
         acc_sat = 16'h7fff;
      end else if ($signed(acc_q) < -32'sd32768) begin
         acc_sat = 16'h8000;
      end else begin
         acc_sat = acc_q[15:0];
      end
   end

   always_comb begin
      case (dec_op_i.opcode)
         `OP_LDI:   result = dec_op_i.imm;
         `OP_ADD:   result = dec_op_i.opa + dec_op_i.opb;
         `OP_SUB:   result = dec_op_i.opa - dec_op_i.opb;
         `OP_AND:   result = dec_op_i.opa & dec_op_i.opb;
         `OP_OR:    result = dec_op_i.opa | dec_op_i.opb;
         `OP_RDACC: result = acc_sat;
         `OP_IN:    result = io_data_i;
         default:   result = '0;
      endcase
   end

   assign wb_en_o   = dec_op_i.valid & dec_op_i.writes_rd;
   assign wb_idx_o  = dec_op_i.rd;
   assign wb_data_o = result;

   // IO port, address from the low imm byte
   assign io_addr_o      = io_addr_t'(dec_op_i.imm[7:0]);
   assign io_data_o      = dec_op_i.opa;
   assign io_wr_strobe_o = dec_op_i.valid && (dec_op_i.opcode == `OP_OUT);
   assign io_rd_strobe_o = dec_op_i.valid && (dec_op_i.opcode == `OP_IN);

   assign is_halt   = dec_op_i.valid && (dec_op_i.opcode == `OP_HALT);
   assign bnz_taken = dec_op_i.valid && (dec_op_i.opcode == `OP_BNZ)
                      && (dec_op_i.opa != '0);

   // Halt also squashes the younger words
   assign jump_taken_o  = bnz_taken | is_halt;
   assign jump_target_o = dec_op_i.target;
   assign halt_o        = is_halt;

endmodule

/* source/dsp_top.sv */
module dsp_top (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              prog_wr_i,
   input  dsp_pkg::pm_addr_t prog_addr_i,
   input  dsp_pkg::instr_t   prog_data_i,
   input  logic              start_i,
   output logic              done_o,
   output dsp_pkg::io_addr_t io_addr_o,
   output dsp_pkg::word_t    io_data_o,
   input  dsp_pkg::word_t    io_data_i,
   output logic              io_wr_strobe_o,
   output logic              io_rd_strobe_o
);
   import dsp_pkg::*;

   pm_addr_t    pc;
   instr_t      pm_rdata;
   instr_t      f_instr;
   logic        fetch_valid;
   logic        running;
   logic        pm_wr;
   reg_idx_t    rd_a_idx;
   reg_idx_t    rd_b_idx;
   word_t       rd_a;
   word_t       rd_b;
   decoded_op_t dec_op;
   logic        wb_en;
   reg_idx_t    wb_idx;
   word_t       wb_data;
   logic        jump_taken;
   pm_addr_t    jump_target;
   logic        halt_seen;

   // Loader is locked out while a program runs
   assign pm_wr  = prog_wr_i & ~running;
   assign done_o = halt_seen;

   program_memory program_memory_i (
      .clk_i       (clk_i),
      .prog_wr_i   (pm_wr),
      .prog_addr_i (prog_addr_i),
      .prog_data_i (prog_data_i),
      .rd_addr_i   (pc),
      .rd_data_o   (pm_rdata)
   );

   fetch_unit fetch_unit_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .start_i       (start_i),
      .jump_taken_i  (jump_taken),
      .jump_target_i (jump_target),
      .halt_i        (halt_seen),
      .pc_o          (pc),
      .instr_i       (pm_rdata),
      .instr_o       (f_instr),
      .fetch_valid_o (fetch_valid),
      .running_o     (running)
   );

   instruction_decoder instruction_decoder_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .instr_i       (f_instr),
      .fetch_valid_i (fetch_valid),
      .flush_i       (jump_taken),
      .rd_a_idx_o    (rd_a_idx),
      .rd_b_idx_o    (rd_b_idx),
      .rd_a_i        (rd_a),
      .rd_b_i        (rd_b),
      .wb_en_i       (wb_en),
      .wb_idx_i      (wb_idx),
      .wb_data_i     (wb_data),
      .dec_op_o      (dec_op)
   );

   register_file register_file_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rd_a_idx_i (rd_a_idx),
      .rd_b_idx_i (rd_b_idx),
      .rd_a_o     (rd_a),
      .rd_b_o     (rd_b),
      .wr_en_i    (wb_en),
      .wr_idx_i   (wb_idx),
      .wr_data_i  (wb_data)
   );

   execute_unit execute_unit_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .dec_op_i       (dec_op),
      .wb_en_o        (wb_en),
      .wb_idx_o       (wb_idx),
      .wb_data_o      (wb_data),
      .jump_taken_o   (jump_taken),
      .jump_target_o  (jump_target),
      .halt_o         (halt_seen),
      .io_addr_o      (io_addr_o),
      .io_data_o      (io_data_o),
      .io_data_i      (io_data_i),
      .io_wr_strobe_o (io_wr_strobe_o),
      .io_rd_strobe_o (io_rd_strobe_o)
   );

endmodule

/* bench/dsp_tb.sv */
`include "dsp_params.svh"

module dsp_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import dsp_pkg::*;

   typedef struct packed {
      io_addr_t addr;
      word_t    data;
   } io_write_t;

   localparam int PROG_DEPTH   = 1 << `DSP_PM_AW;
   localparam int DONE_TIMEOUT = 4000;

   logic      clk;
   logic      rst_n;
   logic      prog_wr;
   pm_addr_t  prog_addr;
   instr_t    prog_data;
   logic      start;
   logic      done;
   io_addr_t  io_addr;
   word_t     io_wdata;
   word_t     io_rdata;
   logic      io_wr_strobe;
   logic      io_rd_strobe;

   logic [31:0] rng_state;
   word_t       io_table [256];
   instr_t      prog [PROG_DEPTH];
   int          prog_len;
   io_write_t   exp_writes [$];
   int          exp_total;
   int          exp_reads;
   int          wr_count;
   int          rd_count;
   logic        done_seen;

   dsp_top dsp_top_i (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .prog_wr_i      (prog_wr),
      .prog_addr_i    (prog_addr),
      .prog_data_i    (prog_data),
      .start_i        (start),
      .done_o         (done),
      .io_addr_o      (io_addr),
      .io_data_o      (io_wdata),
      .io_data_i      (io_rdata),
      .io_wr_strobe_o (io_wr_strobe),
      .io_rd_strobe_o (io_rd_strobe)
   );

   always #10 clk = ~clk;

   // IO responder keyed on the address only
   assign io_rdata = io_table[io_addr];

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic void report_failure();
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endfunction

   function automatic instr_t encode_reg(opcode_t op, int rd, int ra, int rb);
      instr_t w;
      w = '0;
      w[`INSTR_OP_HI:`INSTR_OP_LO] = op;
      w[`INSTR_RD_HI:`INSTR_RD_LO] = 4'(rd);
      w[`INSTR_RA_HI:`INSTR_RA_LO] = 4'(ra);
      w[`INSTR_RB_HI:`INSTR_RB_LO] = 4'(rb);
      return w;
   endfunction

   function automatic instr_t encode_imm(opcode_t op, int rd, int ra, word_t imm);
      instr_t w;
      w = '0;
      w[`INSTR_OP_HI:`INSTR_OP_LO]   = op;
      w[`INSTR_RD_HI:`INSTR_RD_LO]   = 4'(rd);
      w[`INSTR_RA_HI:`INSTR_RA_LO]   = 4'(ra);
      w[`INSTR_IMM_HI:`INSTR_IMM_LO] = imm;
      return w;
   endfunction

   function automatic void add_instr(instr_t w);
      prog[prog_len] = w;
      prog_len++;
   endfunction

   // Instruction set model stepping in program order
   function automatic void model_program();
      word_t              regs [`DSP_NUM_REGS];
      acc_t               acc;
      logic signed [31:0] prod;
      pm_addr_t           pc;
      instr_t             w;
      reg_idx_t           rd;
      word_t              a;
      word_t              b;
      word_t              imm;
      io_write_t          wr;
      logic               halted;
      int                 steps;
      foreach (regs[i]) begin
         regs[i] = '0;
      end
      acc = '0;
      pc = '0;
      halted = 1'b0;
      steps = 0;
      exp_writes.delete();
      exp_reads = 0;
      while (!halted && steps < 10000) begin
         w   = prog[pc];
         rd  = w[`INSTR_RD_HI:`INSTR_RD_LO];
         a   = regs[w[`INSTR_RA_HI:`INSTR_RA_LO]];
         b   = regs[w[`INSTR_RB_HI:`INSTR_RB_LO]];
         imm = w[`INSTR_IMM_HI:`INSTR_IMM_LO];
         pc++;
         steps++;
         case (w[`INSTR_OP_HI:`INSTR_OP_LO])
            `OP_LDI: regs[rd] = imm;
            `OP_ADD: regs[rd] = a + b;
            `OP_SUB: regs[rd] = a - b;
            `OP_AND: regs[rd] = a & b;
            `OP_OR:  regs[rd] = a | b;
            `OP_MAC: begin
               prod = 32'($signed(a)) * 32'($signed(b));
               acc  = acc + prod;
            end
            `OP_CLRACC: acc = '0;
            `OP_RDACC: begin
               // Fits when the top 17 bits are all copies of the sign
               if ((acc[31:15] == '0) || (acc[31:15] == '1)) begin
                  regs[rd] = acc[15:0];
               end else if (acc[31]) begin
                  regs[rd] = 16'h8000;
               end else begin
                  regs[rd] = 16'h7fff;
               end
            end
            `OP_IN: begin
               regs[rd] = io_table[imm[7:0]];
               exp_reads++;
            end
            `OP_OUT: begin
               wr.addr = imm[7:0];
               wr.data = a;
               exp_writes.push_back(wr);
            end
            `OP_BNZ: begin
               if (a != '0) begin
                  pc = w[`DSP_PM_AW-1:0];
               end
            end
            `OP_HALT: halted = 1'b1;
            default: ;
         endcase
      end
      exp_total = exp_writes.size();
      if (!halted) begin
         $display("Test program did not reach HALT in the model");
         report_failure();
      end
   endfunction

   task automatic check_io_write(input io_addr_t addr, input word_t data);
      io_write_t exp;
      wr_count++;
      if (exp_writes.size() == 0) begin
         $display("IO write to address %h was not expected", addr);
         report_failure();
      end else begin
         exp = exp_writes.pop_front();
         if (addr !== exp.addr) begin
            $display("error io_addr_o: got %h, expected %h", addr, exp.addr);
            report_failure();
         end else if (data !== exp.data) begin
            $display("error io_data_o at %h: got %h, expected %h", addr, data, exp.data);
            report_failure();
         end
      end
   endtask

   task automatic check_done(input int n_writes, input int n_reads);
      if (n_writes != exp_total) begin
         $display("error io_wr_strobe_o count: got %h, expected %h", n_writes, exp_total);
         report_failure();
      end else if (n_reads != exp_reads) begin
         $display("error io_rd_strobe_o count: got %h, expected %h", n_reads, exp_reads);
         report_failure();
      end
   endtask

   // Strobes are sampled half a cycle away from the active edge
   always @(negedge clk) begin
      if (io_wr_strobe) begin
         check_io_write(io_addr, io_wdata);
      end else if (io_rd_strobe) begin
         rd_count++;
      end else if (done) begin
         done_seen = 1'b1;
         check_done(wr_count, rd_count);
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (16) next_cycle();
      rst_n = 1'b1;
      next_cycle();
   endtask

   task automatic load_program();
      for (int i = 0; i < prog_len; i++) begin
         prog_wr   = 1'b1;
         prog_addr = pm_addr_t'(i);
         prog_data = prog[i];
         next_cycle();
      end
      prog_wr = 1'b0;
   endtask

   task automatic run_program(input string name);
      int cycles;
      model_program();
      apply_reset();
      load_program();
      wr_count  = 0;
      rd_count  = 0;
      done_seen = 1'b0;
      start = 1'b1;
      next_cycle();
      start = 1'b0;
      cycles = 0;
      while (!done_seen && cycles < DONE_TIMEOUT) begin
         next_cycle();
         cycles++;
      end
      if (!done_seen) begin
         $display("Timeout, %s never raised done_o", name);
         report_failure();
      end
   endtask

   task automatic alu_results();
      prog_len = 0;
      add_instr(encode_imm(`OP_LDI, 1, 0, 16'h1234));
      add_instr(encode_imm(`OP_LDI, 2, 0, 16'hf0f0));
      add_instr(encode_imm(`OP_LDI, 8, 0, 16'hffff));
      add_instr(encode_reg(`OP_ADD, 3, 1, 2));
      add_instr(encode_reg(`OP_SUB, 4, 1, 2));
      add_instr(encode_reg(`OP_AND, 5, 1, 2));
      add_instr(encode_reg(`OP_OR, 6, 1, 2));
      add_instr(encode_reg(`OP_ADD, 7, 8, 8));
      for (int r = 3; r <= 7; r++) begin
         add_instr(encode_imm(`OP_OUT, 0, r, word_t'(16 + r)));
      end
      add_instr(encode_imm(`OP_HALT, 0, 0, 16'h0000));
      run_program("ALU program");
   endtask

   task automatic forwarding_chain();
      prog_len = 0;
      add_instr(encode_imm(`OP_LDI, 1, 0, 16'h0005));
      add_instr(encode_reg(`OP_ADD, 2, 1, 1));
      add_instr(encode_reg(`OP_ADD, 3, 2, 1));
      add_instr(encode_reg(`OP_SUB, 4, 3, 2));
      add_instr(encode_imm(`OP_OUT, 0, 4, 16'h0030));
      add_instr(encode_reg(`OP_ADD, 4, 4, 4));
      add_instr(encode_imm(`OP_OUT, 0, 4, 16'h0031));
      add_instr(encode_reg(`OP_OR, 5, 4, 3));
      add_instr(encode_reg(`OP_AND, 5, 5, 2));
      add_instr(encode_imm(`OP_OUT, 0, 5, 16'h0032));
      add_instr(encode_imm(`OP_HALT, 0, 0, 16'h0000));
      run_program("forwarding program");
   endtask

   task automatic mac_sequence();
      prog_len = 0;
      add_instr(encode_imm(`OP_LDI, 1, 0, 16'h7fff));
      add_instr(encode_reg(`OP_MAC, 0, 1, 1));
      add_instr(encode_imm(`OP_RDACC, 3, 0, 16'h0000));
      add_instr(encode_imm(`OP_OUT, 0, 3, 16'h0040));
      add_instr(encode_imm(`OP_CLRACC, 0, 0, 16'h0000));
      add_instr(encode_imm(`OP_LDI, 4, 0, 16'h8000));
      add_instr(encode_imm(`OP_LDI, 5, 0, 16'h0003));
      add_instr(encode_reg(`OP_MAC, 0, 4, 5));
      add_instr(encode_imm(`OP_RDACC, 6, 0, 16'h0000));
      add_instr(encode_imm(`OP_OUT, 0, 6, 16'h0041));
      add_instr(encode_imm(`OP_CLRACC, 0, 0, 16'h0000));
      add_instr(encode_imm(`OP_LDI, 7, 0, 16'd100));
      add_instr(encode_imm(`OP_LDI, 8, 0, 16'hffec));
      add_instr(encode_reg(`OP_MAC, 0, 7, 8));
      add_instr(encode_reg(`OP_MAC, 0, 7, 7));
      add_instr(encode_imm(`OP_RDACC, 9, 0, 16'h0000));
      add_instr(encode_imm(`OP_OUT, 0, 9, 16'h0042));
      // Two products of 0x40000000 wrap the accumulator negative
      add_instr(encode_imm(`OP_CLRACC, 0, 0, 16'h0000));
      add_instr(encode_reg(`OP_MAC, 0, 4, 4));
      add_instr(encode_reg(`OP_MAC, 0, 4, 4));
      add_instr(encode_imm(`OP_RDACC, 10, 0, 16'h0000));
      add_instr(encode_imm(`OP_OUT, 0, 10, 16'h0043));
      add_instr(encode_imm(`OP_CLRACC, 0, 0, 16'h0000));
      add_instr(encode_imm(`OP_RDACC, 11, 0, 16'h0000));
      add_instr(encode_imm(`OP_OUT, 0, 11, 16'h0044));
      add_instr(encode_imm(`OP_HALT, 0, 0, 16'h0000));
      run_program("MAC program");
   endtask

   task automatic countdown_loop();
      prog_len = 0;
      add_instr(encode_imm(`OP_LDI, 1, 0, 16'h0005));
      add_instr(encode_imm(`OP_LDI, 2, 0, 16'h0001));
      add_instr(encode_imm(`OP_OUT, 0, 1, 16'h0020));
      add_instr(encode_reg(`OP_SUB, 1, 1, 2));
      add_instr(encode_imm(`OP_BNZ, 0, 1, 16'h0002));
      // Squashed on every taken branch
      add_instr(encode_imm(`OP_OUT, 0, 1, 16'h0021));
      add_instr(encode_imm(`OP_OUT, 0, 2, 16'h0022));
      add_instr(encode_imm(`OP_HALT, 0, 0, 16'h0000));
      run_program("countdown loop");
   endtask

   task automatic io_read_sum();
      prog_len = 0;
      add_instr(encode_imm(`OP_IN, 1, 0, 16'h0003));
      add_instr(encode_imm(`OP_IN, 2, 0, 16'h0047));
      add_instr(encode_imm(`OP_IN, 3, 0, 16'h00a5));
      add_instr(encode_imm(`OP_IN, 4, 0, 16'h00ff));
      add_instr(encode_reg(`OP_ADD, 5, 1, 2));
      add_instr(encode_reg(`OP_ADD, 5, 5, 3));
      add_instr(encode_reg(`OP_ADD, 5, 5, 4));
      add_instr(encode_imm(`OP_OUT, 0, 5, 16'h0080));
      add_instr(encode_imm(`OP_OUT, 0, 1, 16'h0081));
      add_instr(encode_imm(`OP_HALT, 0, 0, 16'h0000));
      run_program("IO read program");
   endtask

   task automatic random_programs();
      opcode_t     ops [12];
      logic [31:0] r;
      int          len;
      ops = '{`OP_LDI, `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_MAC, `OP_CLRACC,
              `OP_RDACC, `OP_IN, `OP_OUT, `OP_OUT, 6'h15};
      for (int p = 0; p < 10; p++) begin
         prog_len = 0;
         len = 8 + int'(next_random() >> 28);
         for (int i = 0; i < len; i++) begin
            r = next_random();
            add_instr({ops[int'(r[31:28]) % 12], r[25:0]});
         end
         add_instr(encode_imm(`OP_HALT, 0, 0, 16'h0000));
         run_program("random program");
      end
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      prog_wr   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      start     = 1'b0;
      rng_state = 32'h7588144f;
      prog_len  = 0;
      exp_total = 0;
      exp_reads = 0;
      wr_count  = 0;
      rd_count  = 0;
      done_seen = 1'b0;
      foreach (io_table[i]) begin
         io_table[i] = word_t'(next_random() >> 16) ^ word_t'(i);
      end
      alu_results();
      forwarding_chain();
      mac_sequence();
      countdown_loop();
      io_read_sum();
      random_programs();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* sim.f */
+incdir+source
source/dsp_pkg.sv
source/program_memory.sv
source/fetch_unit.sv
source/instruction_decoder.sv
source/register_file.sv
source/execute_unit.sv
source/dsp_top.sv
bench/dsp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the DSP core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module dsp_tb \
   --Mdir obj_dir -o dsp_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/dsp_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

exit 0
